// ==== logic/decode_pkg.sv ====
package decode_pkg;

    typedef logic [4:0] reg_addr_t;

    //*******************************************************************
    // instruction word views
    //*******************************************************************
    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;            // immediate or branch offset
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } inst_word_t;

    typedef struct packed {
        logic [31:0] pc;
        inst_word_t  inst;
    } fetch_bus_t;

    // opcodes of the kept set
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LB      = 6'b100000;
    localparam logic [5:0] OP_LH      = 6'b100001;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_LBU     = 6'b100100;
    localparam logic [5:0] OP_LHU     = 6'b100101;
    localparam logic [5:0] OP_SB      = 6'b101000;
    localparam logic [5:0] OP_SH      = 6'b101001;
    localparam logic [5:0] OP_SW      = 6'b101011;

    localparam logic [31:0] LINK_OFFSET = 32'd8;   // return past the delay slot

    //*******************************************************************
    // decoded control and stage buses
    //*******************************************************************
    typedef struct packed {
        logic op_ovf;                // signed overflow is trapped
        logic op_add;
        logic op_sub;
        logic op_slt;
        logic op_sltu;
        logic op_and;
        logic op_nor;
        logic op_or;
        logic op_xor;
        logic op_sll;
        logic op_srl;
        logic op_sra;
        logic op_lui;
    } alu_op_t;

    typedef struct packed {
        logic       load;
        logic       store;
        logic [1:0] ls_word;         // 00 byte, 01 half, 10 word
        logic       lb_sign;
        logic       lh_sign;
    } mem_ctrl_t;

    typedef struct packed {
        logic      rf_wen;
        reg_addr_t rf_wdest;         // zero when nothing is written
    } wb_ctrl_t;

    typedef struct packed {
        alu_op_t   alu_op;
        mem_ctrl_t mem;
        logic      jump;
        logic      jump_reg;
        logic      beq;
        logic      bne;
        logic      bgez;
        logic      bgtz;
        logic      blez;
        logic      bltz;
        logic      link;
        logic      shift_by_sa;
        logic      imm_zero;
        logic      imm_sign;
        logic      uses_rs;
        logic      uses_rt;
        logic      is_jbr;
        wb_ctrl_t  wb;
    } dec_ctrl_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } jbr_bus_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic [31:0] alu_operand1;
        logic [31:0] alu_operand2;
        mem_ctrl_t   mem;
        logic [31:0] store_data;
        wb_ctrl_t    wb;
        logic [31:0] pc;
    } exe_bus_t;

endpackage

// ==== logic/id_stage_reg.sv ====
`timescale 1ns/1ps

module id_stage_reg import decode_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       if_over,
    input  logic       id_over,
    input  fetch_bus_t fetch,
    output fetch_bus_t id_bus,
    output logic       id_valid,
    output logic       id_allowin
);

    logic load_en;

    assign id_allowin = ~id_valid | id_over;     // empty, or held one leaves now
    assign load_en    = if_over & id_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (load_en) begin
            id_valid <= 1'b1;
        end else if (id_over) begin
            id_valid <= 1'b0;                    // drained with nothing behind it
        end
    end

    // pc and instruction payload
    always_ff @(posedge clk) begin
        if (load_en) begin
            id_bus <= fetch;
        end
    end

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import decode_pkg::*; (
    input  inst_word_t inst,
    output dec_ctrl_t  ctrl
);

    logic [5:0] op;
    logic [5:0] funct;
    logic [4:0] sa;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       r_alu, r_shift_imm, regimm;
    logic       is_addu, is_subu, is_add, is_sub, is_slt, is_sltu;
    logic       is_and, is_nor, is_or, is_xor;
    logic       is_sll, is_srl, is_sra, is_sllv, is_srlv, is_srav;
    logic       is_jr, is_jalr, is_j, is_jal;
    logic       is_addi, is_addiu, is_slti, is_sltiu;
    logic       is_andi, is_ori, is_xori, is_lui;
    logic       is_lw, is_lh, is_lhu, is_lb, is_lbu, is_sw, is_sh, is_sb;
    logic       is_beq, is_bne, is_bgez, is_bgtz, is_blez, is_bltz;
    logic       is_bltzal, is_bgezal;
    logic       load, store, rd_alu, imm_alu, branch, link;
    logic       wdest_rt, wdest_31, wdest_rd;

    assign op    = inst.r.op;
    assign rs    = inst.r.rs;
    assign rt    = inst.r.rt;
    assign rd    = inst.r.rd;
    assign sa    = inst.r.sa;
    assign funct = inst.r.funct;

    //*******************************************************************
    // recognition
    //*******************************************************************
    assign r_alu       = (op == OP_SPECIAL) & (sa == 5'd0);   // register forms
    assign r_shift_imm = (op == OP_SPECIAL) & (rs == 5'd0);
    assign regimm      = (op == OP_REGIMM);

    assign is_add  = r_alu & (funct == 6'b100000);
    assign is_addu = r_alu & (funct == 6'b100001);
    assign is_sub  = r_alu & (funct == 6'b100010);
    assign is_subu = r_alu & (funct == 6'b100011);
    assign is_and  = r_alu & (funct == 6'b100100);
    assign is_or   = r_alu & (funct == 6'b100101);
    assign is_xor  = r_alu & (funct == 6'b100110);
    assign is_nor  = r_alu & (funct == 6'b100111);
    assign is_slt  = r_alu & (funct == 6'b101010);
    assign is_sltu = r_alu & (funct == 6'b101011);
    assign is_sllv = r_alu & (funct == 6'b000100);
    assign is_srlv = r_alu & (funct == 6'b000110);
    assign is_srav = r_alu & (funct == 6'b000111);
    assign is_sll  = r_shift_imm & (funct == 6'b000000);
    assign is_srl  = r_shift_imm & (funct == 6'b000010);
    assign is_sra  = r_shift_imm & (funct == 6'b000011);
    assign is_jr   = r_alu & (rt == 5'd0) & (rd == 5'd0) & (funct == 6'b001000);
    assign is_jalr = r_alu & (rt == 5'd0) & (rd == 5'd31) & (funct == 6'b001001);

    assign is_addi  = (op == OP_ADDI);
    assign is_addiu = (op == OP_ADDIU);
    assign is_slti  = (op == OP_SLTI);
    assign is_sltiu = (op == OP_SLTIU);
    assign is_andi  = (op == OP_ANDI);
    assign is_ori   = (op == OP_ORI);
    assign is_xori  = (op == OP_XORI);
    assign is_lui   = (op == OP_LUI) & (rs == 5'd0);

    assign is_lw  = (op == OP_LW);
    assign is_lh  = (op == OP_LH);
    assign is_lhu = (op == OP_LHU);
    assign is_lb  = (op == OP_LB);
    assign is_lbu = (op == OP_LBU);
    assign is_sw  = (op == OP_SW);
    assign is_sh  = (op == OP_SH);
    assign is_sb  = (op == OP_SB);

    assign is_j      = (op == OP_J);
    assign is_jal    = (op == OP_JAL);
    assign is_beq    = (op == OP_BEQ);
    assign is_bne    = (op == OP_BNE);
    assign is_bgtz   = (op == OP_BGTZ) & (rt == 5'd0);
    assign is_blez   = (op == OP_BLEZ) & (rt == 5'd0);
    assign is_bltz   = regimm & (rt == 5'b00000);
    assign is_bgez   = regimm & (rt == 5'b00001);
    assign is_bltzal = regimm & (rt == 5'b10000);
    assign is_bgezal = regimm & (rt == 5'b10001);

    //*******************************************************************
    // grouping
    //*******************************************************************
    assign load    = is_lw | is_lh | is_lhu | is_lb | is_lbu;
    assign store   = is_sw | is_sh | is_sb;
    assign rd_alu  = is_addu | is_subu | is_add | is_sub | is_slt | is_sltu
                   | is_and | is_nor | is_or | is_xor
                   | is_sll | is_srl | is_sra | is_sllv | is_srlv | is_srav;
    assign imm_alu = is_addi | is_addiu | is_slti | is_sltiu
                   | is_andi | is_ori | is_xori | is_lui;
    assign branch  = is_beq | is_bne | is_bgez | is_bgtz | is_blez | is_bltz
                   | is_bltzal | is_bgezal;
    assign link    = is_jal | is_jalr | is_bltzal | is_bgezal;

    assign wdest_rt = imm_alu | load;
    assign wdest_31 = is_jal | is_bltzal | is_bgezal;
    assign wdest_rd = rd_alu | is_jalr;

    always_comb begin
        ctrl.alu_op.op_ovf  = is_add | is_addi | is_sub;
        ctrl.alu_op.op_add  = is_addu | is_add | is_addiu | is_addi | load | store | link;
        ctrl.alu_op.op_sub  = is_subu | is_sub;
        ctrl.alu_op.op_slt  = is_slt | is_slti;
        ctrl.alu_op.op_sltu = is_sltu | is_sltiu;
        ctrl.alu_op.op_and  = is_and | is_andi;
        ctrl.alu_op.op_nor  = is_nor;
        ctrl.alu_op.op_or   = is_or | is_ori;
        ctrl.alu_op.op_xor  = is_xor | is_xori;
        ctrl.alu_op.op_sll  = is_sll | is_sllv;
        ctrl.alu_op.op_srl  = is_srl | is_srlv;
        ctrl.alu_op.op_sra  = is_sra | is_srav;
        ctrl.alu_op.op_lui  = is_lui;

        ctrl.mem.load    = load;
        ctrl.mem.store   = store;
        ctrl.mem.ls_word = {is_lw | is_sw, is_lh | is_lhu | is_sh};
        ctrl.mem.lb_sign = is_lb;
        ctrl.mem.lh_sign = is_lh;

        ctrl.jump     = is_j | is_jal | is_jr | is_jalr;
        ctrl.jump_reg = is_jr | is_jalr;
        ctrl.beq      = is_beq;
        ctrl.bne      = is_bne;
        ctrl.bgez     = is_bgez | is_bgezal;
        ctrl.bgtz     = is_bgtz;
        ctrl.blez     = is_blez;
        ctrl.bltz     = is_bltz | is_bltzal;

        ctrl.link        = link;
        ctrl.shift_by_sa = is_sll | is_srl | is_sra;
        ctrl.imm_zero    = is_andi | is_ori | is_xori | is_lui;
        ctrl.imm_sign    = is_addi | is_addiu | is_slti | is_sltiu | load | store;

        // rs of shift-imm and lui is zero, so flagging them is harmless
        ctrl.uses_rs = rd_alu | imm_alu | load | store | branch | is_jr | is_jalr;
        ctrl.uses_rt = rd_alu | is_beq | is_bne | store;
        ctrl.is_jbr  = is_j | is_jal | is_jr | is_jalr | branch;

        ctrl.wb.rf_wen   = wdest_rt | wdest_31 | wdest_rd;
        ctrl.wb.rf_wdest = wdest_rt ? rt :
                           wdest_31 ? 5'd31 :
                           wdest_rd ? rd : 5'd0;     // keeps hazard compare clean
    end

endmodule

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import decode_pkg::*; (
    input  logic [31:0] pc,
    input  inst_word_t  inst,
    input  dec_ctrl_t   ctrl,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    input  logic        id_over,
    output jbr_bus_t    jbr
);

    logic [31:0] bd_pc;
    logic [31:0] offset_ext;
    logic [31:0] j_target;
    logic [31:0] br_target;
    logic        rs_eq_rt;
    logic        rs_ez;
    logic        rs_ltz;
    logic        br_taken;

    assign bd_pc = pc + 32'd4;                   // delay slot pc

    //*******************************************************************
    // targets
    //*******************************************************************
    assign offset_ext = {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
    assign br_target  = bd_pc + offset_ext;
    assign j_target   = ctrl.jump_reg ? rs_value
                                      : {bd_pc[31:28], inst.j.target, 2'b00};

    //*******************************************************************
    // conditions, all signed against zero
    //*******************************************************************
    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ez    = (rs_value == 32'd0);
    assign rs_ltz   = rs_value[31];

    assign br_taken = (ctrl.beq  & rs_eq_rt)
                    | (ctrl.bne  & ~rs_eq_rt)
                    | (ctrl.bgez & ~rs_ltz)
                    | (ctrl.bgtz & ~rs_ltz & ~rs_ez)
                    | (ctrl.blez & (rs_ltz | rs_ez))
                    | (ctrl.bltz & rs_ltz);

    // redirect only once the stage has really finished
    assign jbr.taken  = (ctrl.jump | br_taken) & id_over;
    assign jbr.target = ctrl.jump ? j_target : br_target;

endmodule

// ==== logic/issue_check.sv ====
`timescale 1ns/1ps

module issue_check import decode_pkg::*; #(
    parameter int NUM_WDEST = 3
) (
    input  logic      id_valid,
    input  logic      if_over,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  logic      uses_rs,
    input  logic      uses_rt,
    input  logic      is_jbr,
    input  reg_addr_t wdest [NUM_WDEST],
    output logic      id_over
);

    logic rs_hit;
    logic rt_hit;
    logic rs_wait;
    logic rt_wait;

    always_comb begin
        rs_hit = 1'b0;
        rt_hit = 1'b0;
        for (int i = 0; i < NUM_WDEST; i++) begin
            rs_hit = rs_hit | (rs == wdest[i]);
            rt_hit = rt_hit | (rt == wdest[i]);
        end
    end

    assign rs_wait = uses_rs & (rs != 5'd0) & rs_hit;   // r0 never waits
    assign rt_wait = uses_rt & (rt != 5'd0) & rt_hit;

    // a jump needs fetch finished, else its redirect would be missed
    assign id_over = id_valid & ~rs_wait & ~rt_wait & (~is_jbr | if_over);

endmodule

// ==== logic/exe_bus_builder.sv ====
`timescale 1ns/1ps

module exe_bus_builder import decode_pkg::*; (
    input  fetch_bus_t  fetched,
    input  dec_ctrl_t   ctrl,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    output exe_bus_t    exe_bus
);

    logic [15:0] imm;
    logic [31:0] imm_zext;
    logic [31:0] imm_sext;
    logic [31:0] operand1;
    logic [31:0] operand2;

    assign imm      = fetched.inst.i.imm;
    assign imm_zext = {16'd0, imm};
    assign imm_sext = {{16{imm[15]}}, imm};

    //*******************************************************************
    // operand selection
    //*******************************************************************
    // link forms compute pc + 8 in the alu
    assign operand1 = ctrl.link        ? fetched.pc :
                      ctrl.shift_by_sa ? {27'd0, fetched.inst.r.sa} :
                                         rs_value;

    assign operand2 = ctrl.link     ? LINK_OFFSET :
                      ctrl.imm_zero ? imm_zext :
                      ctrl.imm_sign ? imm_sext :
                                      rt_value;

    //*******************************************************************
    // bus packing
    //*******************************************************************
    always_comb begin
        exe_bus.alu_op       = ctrl.alu_op;
        exe_bus.alu_operand1 = operand1;
        exe_bus.alu_operand2 = operand2;
        exe_bus.mem          = ctrl.mem;
        exe_bus.store_data   = rt_value;         // used by stores only
        exe_bus.wb           = ctrl.wb;
        exe_bus.pc           = fetched.pc;
    end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; #(
    parameter int NUM_WDEST = 3
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        if_over,
    input  fetch_bus_t  fetch,
    input  logic [31:0] rs_value,
    input  logic [31:0] rt_value,
    input  reg_addr_t   wdest [NUM_WDEST],   // exe, mem, wb destinations
    output reg_addr_t   rs,
    output reg_addr_t   rt,
    output jbr_bus_t    jbr,
    output logic        id_over,
    output logic        id_allowin,
    output exe_bus_t    exe_bus,
    output logic [31:0] id_pc
);

    fetch_bus_t id_bus;
    logic       id_valid;
    dec_ctrl_t  ctrl;

    assign rs    = id_bus.inst.r.rs;             // register file read ports
    assign rt    = id_bus.inst.r.rt;
    assign id_pc = id_bus.pc;

    id_stage_reg i_id_stage_reg (
        .clk        (clk),
        .reset      (reset),
        .if_over    (if_over),
        .id_over    (id_over),
        .fetch      (fetch),
        .id_bus     (id_bus),
        .id_valid   (id_valid),
        .id_allowin (id_allowin)
    );

    inst_decoder i_inst_decoder (
        .inst (id_bus.inst),
        .ctrl (ctrl)
    );

    branch_unit i_branch_unit (
        .pc       (id_bus.pc),
        .inst     (id_bus.inst),
        .ctrl     (ctrl),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .id_over  (id_over),
        .jbr      (jbr)
    );

    issue_check #(
        .NUM_WDEST (NUM_WDEST)
    ) i_issue_check (
        .id_valid (id_valid),
        .if_over  (if_over),
        .rs       (rs),
        .rt       (rt),
        .uses_rs  (ctrl.uses_rs),
        .uses_rt  (ctrl.uses_rt),
        .is_jbr   (ctrl.is_jbr),
        .wdest    (wdest),
        .id_over  (id_over)
    );

    exe_bus_builder i_exe_bus_builder (
        .fetched  (id_bus),
        .ctrl     (ctrl),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .exe_bus  (exe_bus)
    );

endmodule

// ==== verification/decode_vectors.svh ====
// one row per instruction
// stimulus    pc, inst, rs_value, rt_value, wdest {exe, mem, wb}, if_over at the check
// expected    id_over, jbr.taken, is_jbr, jbr.target, alu_op, operand1, operand2, mem, wb
// alu_op bits {ovf, add, sub, slt, sltu, and, nor, or, xor, sll, srl, sra, lui}
// mem bits {load, store, ls_word[1:0], lb_sign, lh_sign}, wb bits {rf_wen, rf_wdest}

typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [14:0] wdest;
    logic        if_over;
    logic        id_over;
    logic        taken;
    logic        is_jbr;            // target is compared only for jumps and branches
    logic [31:0] target;
    logic [12:0] alu_op;
    logic [31:0] operand1;
    logic [31:0] operand2;
    logic [5:0]  mem;
    logic [5:0]  wb;
} vector_t;

localparam int NUM_VECTORS = 30;

vector_t vectors [NUM_VECTORS];

task automatic fill_vectors();
    // alu forms
    vectors[0]  = '{32'hbfc00100, 32'h00221821, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'h3, 6'h00, 6'h23};
    vectors[1]  = '{32'hbfc00104, 32'h00221823, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0400, 32'h10, 32'h3, 6'h00, 6'h23};
    vectors[2]  = '{32'hbfc00108, 32'h2422fffc, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'hfffffffc, 6'h00, 6'h22};
    vectors[3]  = '{32'hbfc0010c, 32'h30228001, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0080, 32'h10, 32'h00008001, 6'h00, 6'h22};
    vectors[4]  = '{32'hbfc00110, 32'h34228001, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0020, 32'h10, 32'h00008001, 6'h00, 6'h22};
    vectors[5]  = '{32'hbfc00114, 32'h20228001, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h1800, 32'h10, 32'hffff8001, 6'h00, 6'h22};
    vectors[6]  = '{32'hbfc00118, 32'h2822ffff, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0200, 32'h10, 32'hffffffff, 6'h00, 6'h22};
    vectors[7]  = '{32'hbfc0011c, 32'h00021940, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0008, 32'h5, 32'h3, 6'h00, 6'h23};
    vectors[8]  = '{32'hbfc00120, 32'h3c021234, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0001, 32'h10, 32'h00001234, 6'h00, 6'h22};
    // loads and stores
    vectors[9]  = '{32'hbfc00124, 32'h8c22fffc, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'hfffffffc, 6'h28, 6'h22};
    vectors[10] = '{32'hbfc00128, 32'h84220008, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'h8, 6'h25, 6'h22};
    vectors[11] = '{32'hbfc0012c, 32'h90220010, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'h10, 6'h20, 6'h22};
    vectors[12] = '{32'hbfc00130, 32'ha0220003, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'h3, 6'h10, 6'h00};
    // jumps and branches
    vectors[13] = '{32'hbfc00134, 32'h10220010, 32'h55, 32'h55, 15'h0, 1'b1,
        1'b1, 1'b1, 1'b1, 32'hbfc00178, 13'h0000, 32'h55, 32'h55, 6'h00, 6'h00};
    vectors[14] = '{32'hbfc00140, 32'h10220010, 32'h55, 32'h56, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b1, 32'hbfc00184, 13'h0000, 32'h55, 32'h56, 6'h00, 6'h00};
    vectors[15] = '{32'hbfc00150, 32'h14220010, 32'h55, 32'h56, 15'h0, 1'b1,
        1'b1, 1'b1, 1'b1, 32'hbfc00194, 13'h0000, 32'h55, 32'h56, 6'h00, 6'h00};
    vectors[16] = '{32'hbfc00160, 32'h1c20fffe, 32'h0, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b1, 32'hbfc0015c, 13'h0000, 32'h0, 32'h3, 6'h00, 6'h00};
    vectors[17] = '{32'hbfc00170, 32'h1820fffe, 32'hfffffff0, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b1, 1'b1, 32'hbfc0016c, 13'h0000, 32'hfffffff0, 32'h3, 6'h00, 6'h00};
    vectors[18] = '{32'hbfc00180, 32'h1c20fffe, 32'h80000000, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b1, 32'hbfc0017c, 13'h0000, 32'h80000000, 32'h3, 6'h00, 6'h00};
    vectors[19] = '{32'hbfc00190, 32'h1820fffe, 32'h0, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b1, 1'b1, 32'hbfc0018c, 13'h0000, 32'h0, 32'h3, 6'h00, 6'h00};
    vectors[20] = '{32'hbfc001a0, 32'h08100040, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b1, 1'b1, 32'hb0400100, 13'h0000, 32'h10, 32'h3, 6'h00, 6'h00};
    vectors[21] = '{32'hbfc001b0, 32'h00200008, 32'hbfc00400, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b1, 1'b1, 32'hbfc00400, 13'h0000, 32'hbfc00400, 32'h3, 6'h00, 6'h00};
    vectors[22] = '{32'hbfc001c0, 32'h0c100080, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b1, 1'b1, 32'hb0400200, 13'h0800, 32'hbfc001c0, LINK_OFFSET, 6'h00, 6'h3f};
    vectors[23] = '{32'hbfc001d0, 32'h04300004, 32'hffffffff, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b1, 1'b1, 32'hbfc001e4, 13'h0800, 32'hbfc001d0, LINK_OFFSET, 6'h00, 6'h3f};
    // stalls and their exemptions
    vectors[24] = '{32'hbfc001e0, 32'h00221821, 32'h10, 32'h3, 15'h0040, 1'b1,
        1'b0, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'h3, 6'h00, 6'h23};
    vectors[25] = '{32'hbfc001f0, 32'h8c22fffc, 32'h10, 32'h3, 15'h1d01, 1'b1,
        1'b0, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'hfffffffc, 6'h28, 6'h22};
    vectors[26] = '{32'hbfc00200, 32'h2422fffc, 32'h10, 32'h3, 15'h0842, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0800, 32'h10, 32'hfffffffc, 6'h00, 6'h22};
    vectors[27] = '{32'hbfc00210, 32'h00021823, 32'h0, 32'h3, 15'h00a6, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0400, 32'h0, 32'h3, 6'h00, 6'h23};
    vectors[28] = '{32'hbfc00220, 32'h10220010, 32'h55, 32'h55, 15'h0, 1'b0,
        1'b0, 1'b0, 1'b1, 32'hbfc00264, 13'h0000, 32'h55, 32'h55, 6'h00, 6'h00};
    // mult is not in the kept set
    vectors[29] = '{32'hbfc00230, 32'h00220018, 32'h10, 32'h3, 15'h0, 1'b1,
        1'b1, 1'b0, 1'b0, 32'h0, 13'h0000, 32'h10, 32'h3, 6'h00, 6'h00};
endtask

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

    localparam int NUM_WDEST      = 3;
    localparam int TIMEOUT_CYCLES = 20;

    logic        clk;
    logic        reset;
    logic        if_over;
    fetch_bus_t  fetch;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    reg_addr_t   wdest [NUM_WDEST];
    reg_addr_t   rs;
    reg_addr_t   rt;
    jbr_bus_t    jbr;
    logic        id_over;
    logic        id_allowin;
    exe_bus_t    exe_bus;
    logic [31:0] id_pc;

    int          errors;
    int          tests_run;
    logic        timed_out;

    `include "decode_vectors.svh"

    decode_stage #(
        .NUM_WDEST (NUM_WDEST)
    ) i_decode_stage (
        .clk        (clk),
        .reset      (reset),
        .if_over    (if_over),
        .fetch      (fetch),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .wdest      (wdest),
        .rs         (rs),
        .rt         (rt),
        .jbr        (jbr),
        .id_over    (id_over),
        .id_allowin (id_allowin),
        .exe_bus    (exe_bus),
        .id_pc      (id_pc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic report_mismatch(input int test, input string name,
                                   input logic [31:0] got, input logic [31:0] expected);
        $display("error test %0d: %s is %h, expected %h", test, name, got, expected);
        errors++;
    endtask

    task automatic print_result(input int test, input logic [31:0] pc, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %0d pc %h ok", test, pc);
        end else begin
            $display("test %0d pc %h failed with %0d errors", test, pc, errors - start_errors);
        end
    endtask

    task automatic check_reset();
        int start_errors;
        start_errors = errors;
        @(negedge clk);
        if (id_over !== 1'b0) begin
            report_mismatch(0, "id_over", 32'(id_over), 32'h0);
        end
        if (jbr.taken !== 1'b0) begin
            report_mismatch(0, "jbr.taken", 32'(jbr.taken), 32'h0);
        end
        if (id_allowin !== 1'b1) begin
            report_mismatch(0, "id_allowin", 32'(id_allowin), 32'h1);
        end
        print_result(0, 32'h0, start_errors);
    endtask

    task automatic run_vector(input int k);
        vector_t v;
        int      start_errors;
        int      cycles;
        v = vectors[k];
        start_errors = errors;

        // load the row with no pending writes so the old instruction drains
        @(posedge clk);
        fetch    <= {v.pc, v.inst};
        rs_value <= v.rs_value;
        rt_value <= v.rt_value;
        if_over  <= 1'b1;
        for (int i = 0; i < NUM_WDEST; i++) begin
            wdest[i] <= '0;
        end

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (id_pc !== v.pc && cycles < TIMEOUT_CYCLES);
        if (id_pc !== v.pc) begin
            $display("test %0d: instruction at pc %h never entered the decode stage", k + 1, v.pc);
            errors++;
            timed_out = 1'b1;
            return;
        end

        @(posedge clk);
        wdest[0] <= v.wdest[14:10];              // exe
        wdest[1] <= v.wdest[9:5];                // mem
        wdest[2] <= v.wdest[4:0];                // wb
        if_over  <= v.if_over;
        fetch    <= '0;                          // a nop at pc 0 waits behind the row
        @(negedge clk);

        if (id_over !== v.id_over) begin
            report_mismatch(k + 1, "id_over", 32'(id_over), 32'(v.id_over));
        end
        if (jbr.taken !== v.taken) begin
            report_mismatch(k + 1, "jbr.taken", 32'(jbr.taken), 32'(v.taken));
        end
        if (v.is_jbr && jbr.target !== v.target) begin
            report_mismatch(k + 1, "jbr.target", jbr.target, v.target);
        end
        if (exe_bus.alu_op !== v.alu_op) begin
            report_mismatch(k + 1, "exe_bus.alu_op", 32'(exe_bus.alu_op), 32'(v.alu_op));
        end
        if (exe_bus.alu_operand1 !== v.operand1) begin
            report_mismatch(k + 1, "exe_bus.alu_operand1", exe_bus.alu_operand1, v.operand1);
        end
        if (exe_bus.alu_operand2 !== v.operand2) begin
            report_mismatch(k + 1, "exe_bus.alu_operand2", exe_bus.alu_operand2, v.operand2);
        end
        if (exe_bus.mem !== v.mem) begin
            report_mismatch(k + 1, "exe_bus.mem", 32'(exe_bus.mem), 32'(v.mem));
        end
        if (exe_bus.wb !== v.wb) begin
            report_mismatch(k + 1, "exe_bus.wb", 32'(exe_bus.wb), 32'(v.wb));
        end
        if (exe_bus.store_data !== v.rt_value) begin
            report_mismatch(k + 1, "exe_bus.store_data", exe_bus.store_data, v.rt_value);
        end
        if (exe_bus.pc !== v.pc) begin
            report_mismatch(k + 1, "exe_bus.pc", exe_bus.pc, v.pc);
        end
        if (rs !== v.inst[25:21] || rt !== v.inst[20:16]) begin
            report_mismatch(k + 1, "rs and rt", 32'({rs, rt}), 32'(v.inst[25:16]));
        end

        // a held instruction must stay put for another cycle
        if (!v.id_over) begin
            @(negedge clk);
            if (id_pc !== v.pc) begin
                report_mismatch(k + 1, "id_pc", id_pc, v.pc);
            end
            if (id_over !== 1'b0) begin
                report_mismatch(k + 1, "id_over", 32'(id_over), 32'h0);
            end
            if (id_allowin !== 1'b0) begin
                report_mismatch(k + 1, "id_allowin", 32'(id_allowin), 32'h0);
            end
        end
        print_result(k + 1, v.pc, start_errors);
    endtask

    //*******************************************************************
    // main sequence
    //*******************************************************************
    initial begin
        errors    = 0;
        tests_run = 0;
        timed_out = 1'b0;
        reset     = 1'b1;
        if_over   = 1'b0;
        fetch     = '0;
        rs_value  = '0;
        rt_value  = '0;
        for (int i = 0; i < NUM_WDEST; i++) begin
            wdest[i] = '0;
        end
        fill_vectors();

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        check_reset();

        for (int k = 0; k < NUM_VECTORS; k++) begin
            if (!timed_out) begin
                run_vector(k);
            end
        end

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verification
logic/decode_pkg.sv
logic/id_stage_reg.sv
logic/inst_decoder.sv
logic/branch_unit.sv
logic/issue_check.sv
logic/exe_bus_builder.sv
logic/decode_stage.sv
verification/decode_stage_tb.sv

// ==== Makefile ====
# Verilator flow for the decode stage

BUILD_DIR = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module decode_stage
	verilator --lint-only --timing -f vlog.f --top-module decode_stage_tb

sim:
	verilator --binary --timing -f vlog.f --top-module decode_stage_tb \
		--Mdir $(BUILD_DIR) -o decode_stage_tb
	./$(BUILD_DIR)/decode_stage_tb | tee /dev/stderr | grep -q "All checks passed"

clean:
	rm -rf $(BUILD_DIR)
